// File: Bender.yml
package:
  name: fp_div

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fp_div_pkg.sv
      - hdl/fp_div_classify.sv
      - hdl/fp_div_mant_stage.sv
      - hdl/fp_div_pack.sv
      - hdl/fp_div_top.sv

  - target: simulation
    include_dirs:
      - hdl
    files:
      - verification/fp_div_tb.sv

// File: fp_div.f
+incdir+hdl
hdl/fp_div_pkg.sv
hdl/fp_div_classify.sv
hdl/fp_div_mant_stage.sv
hdl/fp_div_pack.sv
hdl/fp_div_top.sv
verification/fp_div_tb.sv

// File: hdl/fp_div_classify.sv
`default_nettype none

`include "fp_div_params.svh"

module fp_div_classify
    import fp_div_pkg::*;
(
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic                        in_valid,
    input  wire logic [`FP_EXP_W+`FP_MAN_W:0] a,
    input  wire logic [`FP_EXP_W+`FP_MAN_W:0] b,
    output logic                             out_valid,
    output logic                             sign,
    output exp_t                             exp_diff,
    output op_class_t                        op_class,
    output sig_t                             divisor,
    output rem_t                             rem,
    output quot_t                            quot
);

    localparam int SIGN_BIT = `FP_EXP_W + `FP_MAN_W;

    logic [`FP_EXP_W-1:0] a_exp;
    logic [`FP_EXP_W-1:0] b_exp;
    logic [`FP_MAN_W-1:0] a_frac;
    logic [`FP_MAN_W-1:0] b_frac;
    logic                 a_exp_max;
    logic                 b_exp_max;
    logic                 a_zero;
    logic                 b_zero;
    op_class_t            class_next;

    ////////////////////////////////////////
    // Field split and operand checks
    ////////////////////////////////////////

    assign a_exp  = a[SIGN_BIT-1:`FP_MAN_W];
    assign b_exp  = b[SIGN_BIT-1:`FP_MAN_W];
    assign a_frac = a[`FP_MAN_W-1:0];
    assign b_frac = b[`FP_MAN_W-1:0];

    assign a_exp_max = (a_exp == `FP_EXP_W'(`FP_EXP_MAX));
    assign b_exp_max = (b_exp == `FP_EXP_W'(`FP_EXP_MAX));

    // No denormals, zero exponent means zero
    assign a_zero = (a_exp == '0);
    assign b_zero = (b_exp == '0);

    always_comb
    begin
        if (a_exp_max || b_exp_max || b_zero)
            class_next = CLASS_EXCEPTION;
        else if (a_zero)
            class_next = CLASS_ZERO;
        else
            class_next = CLASS_NORMAL;
    end

    ////////////////////////////////////////
    // Stage registers
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        sign     <= a[SIGN_BIT] ^ b[SIGN_BIT];
        exp_diff <= exp_t'({2'b00, a_exp}) - exp_t'({2'b00, b_exp});
        op_class <= class_next;
        // Hidden bit set on both
        divisor  <= {1'b1, b_frac};
        rem      <= {2'b01, a_frac};
        quot     <= '0;
    end

endmodule

`default_nettype wire

// File: hdl/fp_div_mant_stage.sv
`default_nettype none

`include "fp_div_params.svh"

module fp_div_mant_stage
    import fp_div_pkg::*;
#(
    parameter int BITS = `FP_DIV_BITS
)
(
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      in_valid,
    input  wire logic      in_sign,
    input  wire exp_t      in_exp_diff,
    input  wire op_class_t in_op_class,
    input  wire sig_t      in_divisor,
    input  wire rem_t      in_rem,
    input  wire quot_t     in_quot,
    output logic           out_valid,
    output logic           out_sign,
    output exp_t           out_exp_diff,
    output op_class_t      out_op_class,
    output sig_t           out_divisor,
    output rem_t           out_rem,
    output quot_t          out_quot
);

    localparam int REM_W = $bits(rem_t);

    logic [REM_W:0] diff;
    logic           q_bit;
    rem_t           rem_next;
    quot_t          quot_next;

    ////////////////////////////////////////
    // Restoring steps
    ////////////////////////////////////////

    always_comb
    begin
        rem_next  = in_rem;
        quot_next = in_quot;
        diff      = '0;
        q_bit     = 1'b0;
        for (int i = 0; i < BITS; i++)
        begin
            // Trial subtract, top bit is the borrow
            diff  = {1'b0, rem_next} - {2'b00, in_divisor};
            q_bit = ~diff[REM_W];
            if (q_bit)
                rem_next = diff[REM_W-1:0];
            // Remainder below divisor here, so no bit is lost
            rem_next  = {rem_next[REM_W-2:0], 1'b0};
            quot_next = {quot_next[`FP_QUOT_W-2:0], q_bit};
        end
    end

    ////////////////////////////////////////
    // Stage registers
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        out_sign     <= in_sign;
        out_exp_diff <= in_exp_diff;
        out_op_class <= in_op_class;
        out_divisor  <= in_divisor;
        out_rem      <= rem_next;
        out_quot     <= quot_next;
    end

    // Remainder stays bounded across the whole chain of stages
    rem_bound_a: assert property (
        @(posedge clk) disable iff (reset)
        out_valid |-> (out_rem < {out_divisor, 1'b0})
    )
    else
        $error("division remainder out of range");

endmodule

`default_nettype wire

// File: hdl/fp_div_pack.sv
`default_nettype none

`include "fp_div_params.svh"

module fp_div_pack
    import fp_div_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   in_valid,
    input  wire logic                   in_sign,
    input  wire exp_t                   in_exp_diff,
    input  wire op_class_t              in_op_class,
    input  wire quot_t                  in_quot,
    output logic                        out_valid,
    output logic [`FP_EXP_W+`FP_MAN_W:0] result,
    output logic                        exception,
    output logic                        overflow,
    output logic                        underflow
);

    logic                          norm_hi;
    logic [`FP_MAN_W-1:0]          frac;
    exp_t                          exp_res;
    logic                          ovf;
    logic                          unf;
    logic [`FP_EXP_W+`FP_MAN_W:0]  result_next;

    ////////////////////////////////////////
    // Normalize and adjust exponent
    ////////////////////////////////////////

    // Quotient lies in (0.5, 2), one bit of shift at most
    assign norm_hi = in_quot[`FP_QUOT_W-1];
    assign frac    = norm_hi ? in_quot[`FP_QUOT_W-2:1] : in_quot[`FP_QUOT_W-3:0];
    assign exp_res = in_exp_diff + (norm_hi ? exp_t'(`FP_BIAS) : exp_t'(`FP_BIAS - 1));

    assign ovf = (in_op_class == CLASS_NORMAL) && (exp_res >= exp_t'(`FP_EXP_MAX));
    assign unf = (in_op_class == CLASS_NORMAL) && (exp_res <= exp_t'(0));

    always_comb
    begin
        case (in_op_class)
            CLASS_EXCEPTION:
                result_next = '1;
            CLASS_ZERO:
                result_next = {in_sign, {(`FP_EXP_W + `FP_MAN_W){1'b0}}};
            default:
            begin
                if (ovf)
                    // Saturate to signed infinity
                    result_next = {in_sign, {`FP_EXP_W{1'b1}}, {`FP_MAN_W{1'b0}}};
                else if (unf)
                    result_next = {in_sign, {(`FP_EXP_W + `FP_MAN_W){1'b0}}};
                else
                    result_next = {in_sign, exp_res[`FP_EXP_W-1:0], frac};
            end
        endcase
    end

    ////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_valid <= 1'b0;
            exception <= 1'b0;
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end
        else
        begin
            out_valid <= in_valid;
            exception <= in_valid && (in_op_class == CLASS_EXCEPTION);
            overflow  <= in_valid && ovf;
            underflow <= in_valid && unf;
        end
    end

    always_ff @(posedge clk)
    begin
        result <= result_next;
    end

    flags_excl_a: assert property (
        @(posedge clk) disable iff (reset)
        !(overflow && underflow)
    )
    else
        $error("overflow and underflow both set");

    // Flag and word come from different paths of the select
    exc_word_a: assert property (
        @(posedge clk) disable iff (reset)
        exception |-> (out_valid && (result == '1))
    )
    else
        $error("exception without all-ones result");

endmodule

`default_nettype wire

// File: hdl/fp_div_params.svh
`ifndef FP_DIV_PARAMS_SVH
`define FP_DIV_PARAMS_SVH

////////////////////////////////////////
// Single-precision field layout
////////////////////////////////////////

`define FP_EXP_W 8
`define FP_MAN_W 23
`define FP_BIAS 127
`define FP_EXP_MAX 255

////////////////////////////////////////
// Division pipeline split
////////////////////////////////////////

// Quotient bits, including the bit above the binary point
`define FP_QUOT_W 25

// FP_DIV_STAGES * FP_DIV_BITS must equal FP_QUOT_W
`define FP_DIV_BITS 5
`define FP_DIV_STAGES 5

`endif

// File: hdl/fp_div_pkg.sv
`default_nettype none

`include "fp_div_params.svh"

package fp_div_pkg;

    // Operation class, decided once in the first stage
    typedef enum logic [1:0]
    {
        CLASS_NORMAL,
        CLASS_ZERO,
        CLASS_EXCEPTION
    } op_class_t;

    // Significand with hidden bit
    typedef logic [`FP_MAN_W:0] sig_t;

    // Partial remainder, one bit wider than the significand
    typedef logic [`FP_MAN_W+1:0] rem_t;

    typedef logic [`FP_QUOT_W-1:0] quot_t;

    // Signed working exponent, covers ea - eb + bias
    typedef logic signed [`FP_EXP_W+1:0] exp_t;

endpackage

`default_nettype wire

// File: hdl/fp_div_top.sv
`default_nettype none

`include "fp_div_params.svh"

module fp_div_top
    import fp_div_pkg::*;
(
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic                        in_valid,
    input  wire logic [`FP_EXP_W+`FP_MAN_W:0] a,
    input  wire logic [`FP_EXP_W+`FP_MAN_W:0] b,
    output logic                             out_valid,
    output logic [`FP_EXP_W+`FP_MAN_W:0]     result,
    output logic                             exception,
    output logic                             overflow,
    output logic                             underflow
);

    // Index 0 is the classify output, index N the last division stage
    logic      st_valid    [0:`FP_DIV_STAGES];
    logic      st_sign     [0:`FP_DIV_STAGES];
    exp_t      st_exp_diff [0:`FP_DIV_STAGES];
    op_class_t st_op_class [0:`FP_DIV_STAGES];
    sig_t      st_divisor  [0:`FP_DIV_STAGES];
    rem_t      st_rem      [0:`FP_DIV_STAGES];
    quot_t     st_quot     [0:`FP_DIV_STAGES];

    ////////////////////////////////////////
    // Unpack and classify
    ////////////////////////////////////////

    fp_div_classify u_classify
    (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (st_valid[0]),
        .sign      (st_sign[0]),
        .exp_diff  (st_exp_diff[0]),
        .op_class  (st_op_class[0]),
        .divisor   (st_divisor[0]),
        .rem       (st_rem[0]),
        .quot      (st_quot[0])
    );

    ////////////////////////////////////////
    // Significand division
    ////////////////////////////////////////

    for (genvar i = 0; i < `FP_DIV_STAGES; i++)
    begin : g_div
        fp_div_mant_stage
        #(
            .BITS (`FP_DIV_BITS)
        )
        u_stage
        (
            .clk          (clk),
            .reset        (reset),
            .in_valid     (st_valid[i]),
            .in_sign      (st_sign[i]),
            .in_exp_diff  (st_exp_diff[i]),
            .in_op_class  (st_op_class[i]),
            .in_divisor   (st_divisor[i]),
            .in_rem       (st_rem[i]),
            .in_quot      (st_quot[i]),
            .out_valid    (st_valid[i+1]),
            .out_sign     (st_sign[i+1]),
            .out_exp_diff (st_exp_diff[i+1]),
            .out_op_class (st_op_class[i+1]),
            .out_divisor  (st_divisor[i+1]),
            .out_rem      (st_rem[i+1]),
            .out_quot     (st_quot[i+1])
        );
    end

    ////////////////////////////////////////
    // Normalize and pack
    ////////////////////////////////////////

    fp_div_pack u_pack
    (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (st_valid[`FP_DIV_STAGES]),
        .in_sign     (st_sign[`FP_DIV_STAGES]),
        .in_exp_diff (st_exp_diff[`FP_DIV_STAGES]),
        .in_op_class (st_op_class[`FP_DIV_STAGES]),
        .in_quot     (st_quot[`FP_DIV_STAGES]),
        .out_valid   (out_valid),
        .result      (result),
        .exception   (exception),
        .overflow    (overflow),
        .underflow   (underflow)
    );

endmodule

`default_nettype wire

// File: verification/fp_div_tb.sv
`default_nettype none

module fp_div_tb;

    localparam int LATENCY = 7;
    localparam int TIMEOUT = 20;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic [31:0] a;
    logic [31:0] b;
    logic        out_valid;
    logic [31:0] result;
    logic        exception;
    logic        overflow;
    logic        underflow;

    integer seed = 32'h13f8_54d9;
    int     cycle = 0;
    int     error_count = 0;
    int     check_count = 0;
    int     norm_hi_count = 0;
    int     norm_lo_count = 0;

    // Scoreboard, one entry per accepted operation
    logic [31:0] exp_result [$];
    logic [2:0]  exp_flags [$];
    int          exp_issue [$];
    string       exp_name [$];

    fp_div_top DUT
    (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .result    (result),
        .exception (exception),
        .overflow  (overflow),
        .underflow (underflow)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    function automatic int rand_range(input int lo, input int hi);
        int span;
        span = hi - lo + 1;
        return lo + int'($unsigned($random(seed)) % span);
    endfunction

    function automatic logic [31:0] make_float(input int exp_field);
        logic [31:0] bits;
        bits = $random(seed);
        return {bits[31], exp_field[7:0], bits[22:0]};
    endfunction

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Flags are {exception, overflow, underflow}
    task automatic predict(input logic [31:0] a_in, input logic [31:0] b_in,
                           output logic [31:0] res, output logic [2:0] flags);
        int          ea;
        int          eb;
        int          e;
        logic        s;
        logic [47:0] num;
        logic [47:0] q;
        logic [22:0] frac;
        ea = a_in[30:23];
        eb = b_in[30:23];
        s = a_in[31] ^ b_in[31];
        flags = 3'b000;
        if (ea == 255 || eb == 255 || eb == 0)
        begin
            res = 32'hffff_ffff;
            flags = 3'b100;
        end
        else if (ea == 0)
            res = {s, 31'd0};
        else
        begin
            num = {1'b1, a_in[22:0], 24'd0};
            q = num / {24'd0, 1'b1, b_in[22:0]};
            if (q[24])
            begin
                frac = q[23:1];
                e = ea - eb + 127;
                norm_hi_count++;
            end
            else
            begin
                frac = q[22:0];
                e = ea - eb + 126;
                norm_lo_count++;
            end
            if (e >= 255)
            begin
                res = {s, 8'hff, 23'd0};
                flags = 3'b010;
            end
            else if (e <= 0)
            begin
                res = {s, 31'd0};
                flags = 3'b001;
            end
            else
                res = {s, e[7:0], frac};
        end
    endtask

    ////////////////////////////////////////
    // Scoreboard and driver
    ////////////////////////////////////////

    task automatic check_outputs();
        logic [31:0] want_result;
        logic [2:0]  want_flags;
        int          issued;
        string       name;
        if (out_valid === 1'b1)
        begin
            if (exp_result.size() == 0)
            begin
                $display("Error: result at cycle %0d with no operation pending", cycle);
                error_count++;
            end
            else
            begin
                want_result = exp_result.pop_front();
                want_flags = exp_flags.pop_front();
                issued = exp_issue.pop_front();
                name = exp_name.pop_front();
                check_count++;
                if (result !== want_result)
                begin
                    $display("Fail %s result: expected %h actual %h", name, want_result, result);
                    error_count++;
                end
                if ({exception, overflow, underflow} !== want_flags)
                begin
                    $display("Fail %s flags: expected %b actual %b", name, want_flags,
                             {exception, overflow, underflow});
                    error_count++;
                end
                // Sampled on the next edge, last of the seven registers LATENCY edges on
                if (cycle != issued + LATENCY)
                begin
                    $display("Fail %s latency: expected cycle %0d actual cycle %0d", name,
                             issued + LATENCY, cycle);
                    error_count++;
                end
            end
        end
        else
        begin
            if (out_valid !== 1'b0)
            begin
                $display("Error: out_valid is unknown at cycle %0d", cycle);
                error_count++;
            end
            if ({exception, overflow, underflow} !== 3'b000)
            begin
                $display("Error: flags set while out_valid is low at cycle %0d", cycle);
                error_count++;
            end
            if (exp_issue.size() > 0 && cycle - exp_issue[0] > TIMEOUT)
            begin
                $display("Error: %s operation got no result within %0d cycles",
                         exp_name[0], TIMEOUT);
                error_count++;
                void'(exp_result.pop_front());
                void'(exp_flags.pop_front());
                void'(exp_issue.pop_front());
                void'(exp_name.pop_front());
            end
        end
    endtask

    task automatic drive_cycle(input logic valid, input logic [31:0] a_in,
                               input logic [31:0] b_in, input string name);
        logic [31:0] res;
        logic [2:0]  flags;
        @(negedge clk);
        check_outputs();
        in_valid = valid;
        a = a_in;
        b = b_in;
        if (valid)
        begin
            predict(a_in, b_in, res, flags);
            exp_result.push_back(res);
            exp_flags.push_back(flags);
            exp_issue.push_back(cycle);
            exp_name.push_back(name);
        end
    endtask

    task automatic drain_pipeline();
        for (int i = 0; i < TIMEOUT + 4 && exp_result.size() > 0; i++)
            drive_cycle(1'b0, 32'd0, 32'd0, "idle");
        if (exp_result.size() > 0)
        begin
            $display("Error: %0d operations still pending after drain", exp_result.size());
            error_count++;
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial
    begin
        int ea;
        int eb;
        int d;
        reset = 1'b1;
        in_valid = 1'b0;
        a = 32'd0;
        b = 32'd0;

        for (int i = 0; i < 10; i++)
        begin
            @(negedge clk);
            if (out_valid !== 1'b0 || {exception, overflow, underflow} !== 3'b000)
            begin
                $display("Error: outputs active during reset at cycle %0d", cycle);
                error_count++;
            end
        end
        reset = 1'b0;

        // Idle after reset
        for (int i = 0; i < 20; i++)
            drive_cycle(1'b0, 32'd0, 32'd0, "idle");

        for (int i = 0; i < 2000; i++)
        begin
            if (rand_range(0, 3) == 0)
                drive_cycle(1'b0, 32'd0, 32'd0, "idle");
            drive_cycle(1'b1, make_float(rand_range(1, 254)), make_float(rand_range(1, 254)),
                        "normal");
        end
        drain_pipeline();

        for (int i = 0; i < 100; i++)
        begin
            case (i % 4)
                0: drive_cycle(1'b1, make_float(255), make_float(rand_range(0, 255)),
                               "exception");
                1: drive_cycle(1'b1, make_float(rand_range(0, 255)), make_float(255),
                               "exception");
                2: drive_cycle(1'b1, make_float(rand_range(1, 254)), make_float(0),
                               "exception");
                default: drive_cycle(1'b1, make_float(0), make_float(0), "exception");
            endcase
        end
        drain_pipeline();

        // Fraction bits of a zero dividend are ignored
        for (int i = 0; i < 100; i++)
            drive_cycle(1'b1, make_float(0), make_float(rand_range(1, 254)), "zero_dividend");
        drain_pipeline();

        for (int i = 0; i < 200; i++)
        begin
            drive_cycle(1'b1, make_float(rand_range(200, 254)), make_float(rand_range(1, 60)),
                        "overflow");
            drive_cycle(1'b1, make_float(rand_range(1, 60)), make_float(rand_range(200, 254)),
                        "underflow");
        end
        drain_pipeline();

        // Exponent differences at the edges of the range
        for (int i = 0; i < 200; i++)
        begin
            case (i % 4)
                0: d = 127;
                1: d = 128;
                2: d = -126;
                default: d = -127;
            endcase
            if (d > 0)
            begin
                eb = rand_range(1, 126);
                ea = eb + d;
            end
            else
            begin
                ea = rand_range(1, 127);
                eb = ea - d;
            end
            drive_cycle(1'b1, make_float(ea), make_float(eb), "boundary");
        end
        drain_pipeline();

        // in_valid held high every cycle
        for (int i = 0; i < 200; i++)
            drive_cycle(1'b1, make_float(rand_range(1, 254)), make_float(rand_range(1, 254)),
                        "throughput");
        drain_pipeline();

        for (int i = 0; i < 20; i++)
            drive_cycle(1'b0, 32'd0, 32'd0, "idle");

        if (norm_hi_count == 0 || norm_lo_count == 0)
        begin
            $display("Error: a normalization case was never exercised");
            error_count++;
        end

        $display("%0d results checked, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
